//--- tb.f
+incdir+.
valu_pkg.sv
valu_insn_if.sv
simd_alu.sv
valu_insn_queue.sv
valu_issue.sv
valu_result_queue.sv
valu.sv
tb_valu.sv

//--- Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module tb_valu -Mdir obj_dir -o sim_valu

run: compile
	./obj_dir/sim_valu | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_valu.sv
`timescale 1ns/1ps
`include "valu_settings.svh"

module tb_valu import valu_pkg::*; ();

  // One expected register file write
  typedef struct {
    result_t res;
    bit      last;
  } expect_t;

  logic                      clk_i = 1'b0;
  logic                      rst_ni;
  vinsn_t                    insn_i;
  logic                      insn_valid_i;
  logic                      insn_ready_o;
  elen_t [1:0]               operand_i;
  logic  [1:0]               operand_valid_i;
  logic  [1:0]               operand_ready_o;
  logic                      result_req_o;
  vid_t                      result_id_o;
  vaddr_t                    result_addr_o;
  elen_t                     result_wdata_o;
  strb_t                     result_be_o;
  logic                      result_gnt_i;
  logic [`VALU_NR_VINSN-1:0] vinsn_done_o;

  // Stimulus waiting to be sent, and the scoreboard
  vinsn_t      insn_q[$];
  elen_t       op0_q[$];
  elen_t       op1_q[$];
  expect_t     exp_q[$];
  vid_t        accepted_q[$];
  vid_t        done_seen_q[$];
  bit          gnt_en;
  int          pending;
  int          ack0_cnt;
  int          ack1_cnt;
  strb_t       last_be;
  bit          hold_valid;
  result_t     hold_res;
  logic [31:0] lfsr_q = 32'd7244;

  always #50 clk_i = ~clk_i;

  valu dut0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (insn_i),
    .insn_valid_i    (insn_valid_i),
    .insn_ready_o    (insn_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_req_o    (result_req_o),
    .result_id_o     (result_id_o),
    .result_addr_o   (result_addr_o),
    .result_wdata_o  (result_wdata_o),
    .result_be_o     (result_be_o),
    .result_gnt_i    (result_gnt_i),
    .vinsn_done_o    (vinsn_done_o)
  );

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // Random words and reference model
  ////////////////////////////////////////

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic bit lfsr_bit();
    bit out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic elen_t random_word();
    elen_t w;
    int    i;
    w = '0;
    for (i = 0; i < 64; i++) begin
      w = {w[62:0], lfsr_bit()};
    end
    return w;
  endfunction

  function automatic int elem_bits(vew_e vew);
    return 8 << int'(vew);
  endfunction

  function automatic elen_t elem_mask(int bits);
    return (bits == 64) ? {64{1'b1}} : ((64'd1 << bits) - 64'd1);
  endfunction

  // Low element of the scalar copied into every element slot
  function automatic elen_t replicate_scalar(elen_t scalar, vew_e vew);
    elen_t w;
    int    bits;
    int    e;
    bits = elem_bits(vew);
    w    = '0;
    for (e = 0; e < 64 / bits; e++) begin
      w = w | ((scalar & elem_mask(bits)) << (e * bits));
    end
    return w;
  endfunction

  // Each element computed on its own and wrapped at the element width
  function automatic elen_t ref_alu(alu_op_e op, vew_e vew, elen_t a, elen_t b);
    elen_t ea;
    elen_t eb;
    elen_t er;
    elen_t res;
    int    bits;
    int    e;
    bits = elem_bits(vew);
    res  = '0;
    for (e = 0; e < 64 / bits; e++) begin
      ea = (a >> (e * bits)) & elem_mask(bits);
      eb = (b >> (e * bits)) & elem_mask(bits);
      case (op)
        ALU_ADD: er = ea + eb;
        ALU_SUB: er = ea - eb;
        ALU_AND: er = ea & eb;
        ALU_OR:  er = ea | eb;
        default: er = ea ^ eb;
      endcase
      res = res | ((er & elem_mask(bits)) << (e * bits));
    end
    return res;
  endfunction

  function automatic elen_t byte_mask(strb_t be);
    elen_t m;
    int    i;
    for (i = 0; i < 8; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  // Instruction with its operand words and expected writes
  task automatic queue_insn(input vid_t id, input alu_op_e op, input vew_e vsew,
                            input int vl, input int vd, input bit use_scalar,
                            input elen_t scalar);
    vinsn_t  insn;
    expect_t e;
    elen_t   a;
    elen_t   b;
    int      epw;
    int      left;
    int      word;
    insn.id         = id;
    insn.op         = op;
    insn.vsew       = vsew;
    insn.vl         = vlen_t'(vl);
    insn.vd         = 5'(vd);
    insn.use_scalar = use_scalar;
    insn.scalar     = scalar;
    insn_q.push_back(insn);
    epw  = 64 / elem_bits(vsew);
    left = vl;
    word = 0;
    while (left > 0) begin
      if (use_scalar) begin
        a = replicate_scalar(scalar, vsew);
      end else begin
        a = random_word();
        op0_q.push_back(a);
      end
      b = random_word();
      op1_q.push_back(b);
      e.res.id    = id;
      e.res.addr  = vaddr_t'(vd * `VALU_REG_WORDS + word);
      e.res.wdata = ref_alu(op, vsew, a, b);
      e.res.be    = strb_t'((1 << (((left < epw) ? left : epw) * elem_bits(vsew) / 8)) - 1);
      e.last      = (left <= epw);
      exp_q.push_back(e);
      left = left - epw;
      word++;
    end
  endtask

  ////////////////////////////////////////
  // Cycle driver and scoreboard
  ////////////////////////////////////////

  // Entered on a falling edge, returns on the next one
  task automatic step_cycle();
    expect_t                   e;
    result_t                   head;
    logic [`VALU_NR_VINSN-1:0] done_exp;
    int                        i;
    insn_valid_i       = (insn_q.size() != 0);
    operand_valid_i[0] = (op0_q.size() != 0);
    operand_valid_i[1] = (op1_q.size() != 0);
    if (insn_q.size() != 0) insn_i = insn_q[0];
    if (op0_q.size() != 0) operand_i[0] = op0_q[0];
    if (op1_q.size() != 0) operand_i[1] = op1_q[0];
    // Grant only what is requested
    result_gnt_i = gnt_en && result_req_o;
    #1;
    head.id    = result_id_o;
    head.addr  = result_addr_o;
    head.wdata = result_wdata_o;
    head.be    = result_be_o;
    check_value("result_req_o", result_req_o, pending != 0);
    if (pending == `VALU_RESULT_DEPTH) begin
      check_value("operand_ready_o", operand_ready_o, 2'b00);
    end
    // Request held unchanged while not granted
    if (hold_valid) begin
      check_value("held result", head, hold_res);
    end
    done_exp = '0;
    if (result_gnt_i) begin
      if (exp_q.size() == 0) begin
        fail_now("Result granted while no word was expected");
      end
      e = exp_q.pop_front();
      check_value("result_id_o", result_id_o, e.res.id);
      check_value("result_addr_o", result_addr_o, e.res.addr);
      check_value("result_be_o", result_be_o, e.res.be);
      check_value("result_wdata_o", result_wdata_o & byte_mask(e.res.be),
                  e.res.wdata & byte_mask(e.res.be));
      last_be = result_be_o;
      if (e.last) done_exp[e.res.id] = 1'b1;
    end
    check_value("vinsn_done_o", vinsn_done_o, done_exp);
    for (i = 0; i < `VALU_NR_VINSN; i++) begin
      if (vinsn_done_o[i]) done_seen_q.push_back(vid_t'(i));
    end
    // Transfers taken by the coming rising edge
    if (insn_valid_i && insn_ready_o) begin
      accepted_q.push_back(insn_q[0].id);
      void'(insn_q.pop_front());
    end
    // Any ready on operand 0 counts, with or without a word offered
    if (operand_ready_o[0]) begin
      if (operand_valid_i[0]) begin
        void'(op0_q.pop_front());
      end
      ack0_cnt++;
    end
    if (operand_valid_i[1] && operand_ready_o[1]) begin
      void'(op1_q.pop_front());
      ack1_cnt++;
      pending++;
    end
    if (result_gnt_i) pending--;
    hold_valid = result_req_o && !result_gnt_i;
    hold_res   = head;
    @(negedge clk_i);
  endtask

  task automatic run_cycles(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      step_cycle();
    end
  endtask

  task automatic drain(input int max_cycles);
    int cycles;
    cycles = 0;
    while (insn_q.size() != 0 || exp_q.size() != 0) begin
      if (cycles >= max_cycles) begin
        fail_now($sformatf("Timeout with %0d words still expected after %0d cycles",
                           exp_q.size(), max_cycles));
      end
      step_cycle();
      cycles++;
    end
  endtask

  task automatic start_test();
    gnt_en   = 1'b1;
    ack0_cnt = 0;
    ack1_cnt = 0;
    accepted_q.delete();
    done_seen_q.delete();
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_add_ew64();
    start_test();
    // vd 2 maps to words 32 to 35
    queue_insn(3'd1, ALU_ADD, EW64, 4, 2, 1'b0, '0);
    drain(100);
  endtask

  task automatic test_sub_xor_ew8();
    start_test();
    queue_insn(3'd2, ALU_SUB, EW8, 16, 3, 1'b0, '0);
    queue_insn(3'd3, ALU_XOR, EW8, 8, 4, 1'b0, '0);
    drain(100);
  endtask

  task automatic test_scalar_ew16();
    start_test();
    queue_insn(3'd4, ALU_ADD, EW16, 8, 5, 1'b1, 64'h1234_5678_9abc_def0);
    drain(100);
    check_value("operand 0 acks", ack0_cnt, 0);
    check_value("operand 1 acks", ack1_cnt, 2);
  endtask

  task automatic test_partial_word();
    int i;
    int pulses;
    start_test();
    queue_insn(3'd5, ALU_ADD, EW32, 5, 6, 1'b0, '0);
    drain(100);
    check_value("last result_be_o", last_be, 8'h0f);
    pulses = 0;
    for (i = 0; i < done_seen_q.size(); i++) begin
      if (done_seen_q[i] == 3'd5) pulses++;
    end
    check_value("done pulses for id 5", pulses, 1);
  endtask

  task automatic test_backpressure();
    start_test();
    gnt_en = 1'b0;
    queue_insn(3'd6, ALU_AND, EW64, 4, 7, 1'b0, '0);
    run_cycles(8);
    check_value("pending results", pending, `VALU_RESULT_DEPTH);
    check_value("operand 1 acks", ack1_cnt, `VALU_RESULT_DEPTH);
    gnt_en = 1'b1;
    drain(100);
  endtask

  task automatic test_insn_queue_full();
    int i;
    start_test();
    gnt_en = 1'b0;
    queue_insn(3'd0, ALU_OR, EW64, 1, 8, 1'b0, '0);
    queue_insn(3'd1, ALU_ADD, EW32, 2, 9, 1'b0, '0);
    queue_insn(3'd2, ALU_XOR, EW16, 4, 10, 1'b0, '0);
    queue_insn(3'd3, ALU_SUB, EW8, 8, 11, 1'b0, '0);
    queue_insn(3'd7, ALU_AND, EW64, 1, 12, 1'b0, '0);
    run_cycles(10);
    check_value("accepted instructions", accepted_q.size(), `VALU_INSN_DEPTH);
    check_value("insn_ready_o", insn_ready_o, 1'b0);
    gnt_en = 1'b1;
    drain(200);
    // Done pulses follow acceptance order
    check_value("done pulse count", done_seen_q.size(), accepted_q.size());
    for (i = 0; i < accepted_q.size(); i++) begin
      check_value("done id", done_seen_q[i], accepted_q[i]);
    end
  endtask

  initial begin
    rst_ni          = 1'b0;
    insn_i          = '0;
    insn_valid_i    = 1'b0;
    operand_i       = '0;
    operand_valid_i = 2'b00;
    result_gnt_i    = 1'b0;
    gnt_en          = 1'b1;
    pending         = 0;
    hold_valid      = 1'b0;
    hold_res        = '0;
    last_be         = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_value("insn_ready_o", insn_ready_o, 1'b1);
    check_value("operand_ready_o", operand_ready_o, 2'b00);
    check_value("result_req_o", result_req_o, 1'b0);
    check_value("vinsn_done_o", vinsn_done_o, '0);
    @(negedge clk_i);
    test_add_ew64();
    test_sub_xor_ew8();
    test_scalar_ew16();
    test_partial_word();
    test_backpressure();
    test_insn_queue_full();
    $display("Regression passed");
    $finish;
  end

endmodule

//--- valu.sv
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu import valu_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Sequencer
  input  vinsn_t                    insn_i,
  input  logic                      insn_valid_i,
  output logic                      insn_ready_o,
  // Operand queues
  input  elen_t [1:0]               operand_i,
  input  logic  [1:0]               operand_valid_i,
  output logic  [1:0]               operand_ready_o,
  // Vector register file
  output logic                      result_req_o,
  output vid_t                      result_id_o,
  output vaddr_t                    result_addr_o,
  output elen_t                     result_wdata_o,
  output strb_t                     result_be_o,
  input  logic                      result_gnt_i,
  output logic [`VALU_NR_VINSN-1:0] vinsn_done_o
);

  logic    result_full;
  logic    push;
  result_t push_data;
  result_t head;

  valu_insn_if insn_link ();

  valu_insn_queue i_insn_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (insn_i),
    .insn_valid_i (insn_valid_i),
    .insn_ready_o (insn_ready_o),
    .issue        (insn_link),
    .pop_i        (result_gnt_i),
    .vinsn_done_o (vinsn_done_o)
  );

  valu_issue i_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue           (insn_link),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_full_i   (result_full),
    .push_o          (push),
    .push_data_o     (push_data)
  );

  // Register file grant pops the head
  valu_result_queue #(
    .payload_t (result_t)
  ) i_result_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .data_i  (push_data),
    .full_o  (result_full),
    .valid_o (result_req_o),
    .data_o  (head),
    .pop_i   (result_gnt_i)
  );

  assign result_id_o    = head.id;
  assign result_addr_o  = head.addr;
  assign result_wdata_o = head.wdata;
  assign result_be_o    = head.be;

endmodule

//--- valu_result_queue.sv
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_result_queue #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = `VALU_RESULT_DEPTH
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     pop_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_pnt_q, rd_pnt_q;
  logic [PTR_W:0]   cnt_q;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (cnt_q == DEPTH);
  assign valid_o = (cnt_q != '0);
  // Head entry held stable until granted
  assign data_o  = mem[rd_pnt_q];

  always_ff @(posedge clk_i) begin
    if (push_i) mem[wr_pnt_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_pnt_q <= next_ptr(wr_pnt_q);
      if (pop_i) rd_pnt_q <= next_ptr(rd_pnt_q);
      // Push and pop together keep the count
      if (push_i && !pop_i) cnt_q <= cnt_q + 1'b1;
      else if (!push_i && pop_i) cnt_q <= cnt_q - 1'b1;
    end
  end

  // Grant only follows a request
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> valid_o);

endmodule

//--- valu_issue.sv
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_issue import valu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  valu_insn_if.issue  issue,
  input  elen_t [1:0] operand_i,
  input  logic  [1:0] operand_valid_i,
  output logic  [1:0] operand_ready_o,
  input  logic        result_full_i,
  output logic        push_o,
  output result_t     push_data_o
);

  elen_t      scalar_rep;
  elen_t      operand_a;
  elen_t      alu_result;
  logic [3:0] epw;
  logic [3:0] elem_cnt;
  logic [3:0] byte_cnt;
  logic       last_word;
  logic       operands_ok;
  logic       fire;

  // Word index within the instruction
  vlen_t word_idx_q;

  ////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////

  // Scalar repeated once per element
  always_comb begin
    case (issue.issue_insn.vsew)
      EW8:     scalar_rep = {8{issue.issue_insn.scalar[7:0]}};
      EW16:    scalar_rep = {4{issue.issue_insn.scalar[15:0]}};
      EW32:    scalar_rep = {2{issue.issue_insn.scalar[31:0]}};
      default: scalar_rep = issue.issue_insn.scalar;
    endcase
  end

  assign operand_a = issue.issue_insn.use_scalar ? scalar_rep : operand_i[0];

  simd_alu i_simd_alu (
    .operand_a_i (operand_a),
    .operand_b_i (operand_i[1]),
    .op_i        (issue.issue_insn.op),
    .vew_i       (issue.issue_insn.vsew),
    .result_o    (alu_result)
  );

  ////////////////////////////////////////
  // Handshake and issue
  ////////////////////////////////////////

  // Operand 0 is not needed with a scalar
  assign operands_ok = operand_valid_i[1] && (operand_valid_i[0] || issue.issue_insn.use_scalar);
  assign fire        = issue.issue_valid && !result_full_i && operands_ok;

  assign operand_ready_o  = fire ? {1'b1, !issue.issue_insn.use_scalar} : 2'b00;
  assign push_o           = fire;
  assign issue.issue_step = fire;
  assign issue.issue_done = fire && last_word;

  // Elements covered by this word
  assign epw       = elems_per_word(issue.issue_insn.vsew);
  assign last_word = issue.issue_remaining <= vlen_t'(epw);
  assign elem_cnt  = last_word ? issue.issue_remaining[3:0] : epw;
  // Never more than 8 bytes
  assign byte_cnt  = elem_cnt << issue.issue_insn.vsew;

  always_comb begin
    push_data_o.id    = issue.issue_insn.id;
    push_data_o.wdata = alu_result;
    push_data_o.addr  = vaddr_t'(issue.issue_insn.vd) * vaddr_t'(`VALU_REG_WORDS)
                      + vaddr_t'(word_idx_q);
    for (int b = 0; b < 8; b++) begin
      push_data_o.be[b] = 4'(b) < byte_cnt;
    end
  end

  // Counts words and clears at the end of each instruction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_idx_q <= '0;
    end else if (issue.issue_done) begin
      word_idx_q <= '0;
    end else if (fire) begin
      word_idx_q <= word_idx_q + 1'b1;
    end
  end

  // Word counter agrees with the queue's remaining element count
  a_word_idx: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fire |-> (vlen_t'(word_idx_q * epw) + issue.issue_remaining == issue.issue_insn.vl));

endmodule

//--- valu_insn_queue.sv
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_insn_queue import valu_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vinsn_t                    insn_i,
  input  logic                      insn_valid_i,
  output logic                      insn_ready_o,
  valu_insn_if.queue                issue,
  input  logic                      pop_i,
  output logic [`VALU_NR_VINSN-1:0] vinsn_done_o
);

  localparam int unsigned DEPTH = `VALU_INSN_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Instruction storage
  vinsn_t mem [DEPTH];

  // Accept, issue and commit phase pointers
  logic [PTR_W-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  logic [PTR_W:0]   issue_cnt_q, commit_cnt_q;

  // Per-instruction element counters
  vlen_t issue_rem_d, issue_rem_q;
  vlen_t commit_rem_d, commit_rem_q;

  logic       accept;
  logic       commit_done;
  logic [3:0] epw_issue, epw_commit;

  // Full until the oldest instruction has committed
  assign insn_ready_o = (commit_cnt_q < DEPTH);
  assign accept       = insn_valid_i && insn_ready_o;

  assign issue.issue_insn      = mem[issue_pnt_q];
  assign issue.issue_valid     = (issue_cnt_q != '0);
  assign issue.issue_remaining = issue_rem_q;
  assign issue.commit_insn     = mem[commit_pnt_q];
  assign issue.commit_valid    = (commit_cnt_q != '0);

  assign epw_issue  = elems_per_word(issue.issue_insn.vsew);
  assign epw_commit = elems_per_word(issue.commit_insn.vsew);

  // Last pop of the commit head
  assign commit_done = pop_i && issue.commit_valid && (commit_rem_q <= vlen_t'(epw_commit));

  always_comb begin
    vinsn_done_o = '0;
    if (commit_done) begin
      vinsn_done_o[issue.commit_insn.id] = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Element counters
  ////////////////////////////////////////

  always_comb begin
    issue_rem_d = issue_rem_q;
    if (issue.issue_step) begin
      issue_rem_d = (issue_rem_q <= vlen_t'(epw_issue)) ? '0 : issue_rem_q - vlen_t'(epw_issue);
    end
    // Reload from the next instruction, stored or arriving now
    if (issue.issue_done) begin
      if (issue_cnt_q > 1) issue_rem_d = mem[next_ptr(issue_pnt_q)].vl;
      else if (accept) issue_rem_d = insn_i.vl;
    end else if (!issue.issue_valid && accept) begin
      issue_rem_d = insn_i.vl;
    end
  end

  always_comb begin
    commit_rem_d = commit_rem_q;
    // Saturate since the last word may be partial
    if (pop_i) begin
      commit_rem_d = (commit_rem_q <= vlen_t'(epw_commit)) ? '0
                                                          : commit_rem_q - vlen_t'(epw_commit);
    end
    if (commit_done) begin
      if (commit_cnt_q > 1) commit_rem_d = mem[next_ptr(commit_pnt_q)].vl;
      else if (accept) commit_rem_d = insn_i.vl;
    end else if (!issue.commit_valid && accept) begin
      commit_rem_d = insn_i.vl;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) mem[accept_pnt_q] <= insn_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      issue_rem_q  <= '0;
      commit_rem_q <= '0;
    end else begin
      issue_rem_q  <= issue_rem_d;
      commit_rem_q <= commit_rem_d;
      if (accept) accept_pnt_q <= next_ptr(accept_pnt_q);
      if (issue.issue_done) issue_pnt_q <= next_ptr(issue_pnt_q);
      if (commit_done) commit_pnt_q <= next_ptr(commit_pnt_q);
      // Occupancy of each phase
      if (accept && !issue.issue_done) issue_cnt_q <= issue_cnt_q + 1'b1;
      else if (!accept && issue.issue_done) issue_cnt_q <= issue_cnt_q - 1'b1;
      if (accept && !commit_done) commit_cnt_q <= commit_cnt_q + 1'b1;
      else if (!accept && commit_done) commit_cnt_q <= commit_cnt_q - 1'b1;
    end
  end

  // Every granted word belongs to an instruction still waiting for commit
  a_pop_tracked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> issue.commit_valid);

  // Sequencer never sends an empty instruction
  a_no_zero_vl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (insn_i.vl != '0));

endmodule

//--- simd_alu.sv
`timescale 1ns/1ps

module simd_alu import valu_pkg::*; (
  input  elen_t   operand_a_i,
  input  elen_t   operand_b_i,
  input  alu_op_e op_i,
  input  vew_e    vew_i,
  output elen_t   result_o
);

  // Bytes that open a new element
  logic [7:0] elem_start;

  logic  is_sub;
  elen_t operand_b_eff;
  elen_t addsub_res;

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      case (vew_i)
        EW8:     elem_start[i] = 1'b1;
        EW16:    elem_start[i] = (i % 2) == 0;
        EW32:    elem_start[i] = (i % 4) == 0;
        default: elem_start[i] = (i == 0);
      endcase
    end
  end

  // Subtraction as a + ~b + 1
  assign is_sub        = (op_i == ALU_SUB);
  assign operand_b_eff = is_sub ? ~operand_b_i : operand_b_i;

  ////////////////////////////////////////
  // Byte-wise carry chain
  ////////////////////////////////////////

  always_comb begin : p_addsub
    logic       carry;
    logic [8:0] byte_sum;
    carry      = 1'b0;
    byte_sum   = '0;
    addsub_res = '0;
    for (int i = 0; i < 8; i++) begin
      // Chain is cut at each element boundary
      if (elem_start[i]) carry = is_sub;
      byte_sum = {1'b0, operand_a_i[8*i +: 8]} + {1'b0, operand_b_eff[8*i +: 8]}
               + {8'd0, carry};
      addsub_res[8*i +: 8] = byte_sum[7:0];
      carry = byte_sum[8];
    end
  end

  // Logic ops need no element split
  always_comb begin
    case (op_i)
      ALU_ADD,
      ALU_SUB: result_o = addsub_res;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      default: result_o = '0;
    endcase
  end

endmodule

//--- valu_insn_if.sv
`timescale 1ns/1ps

// Link between the instruction queue and the issue stage
interface valu_insn_if import valu_pkg::*; ();

  // Instruction at the issue head
  vinsn_t issue_insn;
  logic   issue_valid;
  // Elements of the head instruction still to issue
  vlen_t  issue_remaining;
  // One word issued, strobe
  logic   issue_step;
  // Last word of the head instruction issued, strobe
  logic   issue_done;

  // Oldest instruction still waiting for commits
  vinsn_t commit_insn;
  logic   commit_valid;

  modport queue (
    output issue_insn, issue_valid, issue_remaining, commit_insn, commit_valid,
    input  issue_step, issue_done
  );

  modport issue (
    input  issue_insn, issue_valid, issue_remaining,
    output issue_step, issue_done
  );

endinterface

//--- valu_pkg.sv
`include "valu_settings.svh"

package valu_pkg;

  // One data word and its byte enables
  typedef logic [63:0] elen_t;
  typedef logic [7:0]  strb_t;

  // Element width inside a word
  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vew_e;

  // Kept integer operations
  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

  typedef logic [$clog2(`VALU_NR_VINSN)-1:0] vid_t;
  typedef logic [`VALU_VLEN_W-1:0]           vlen_t;
  typedef logic [`VALU_ADDR_W-1:0]           vaddr_t;

  // Instruction as sent by the sequencer
  typedef struct packed {
    vid_t       id;
    alu_op_e    op;
    vew_e       vsew;
    vlen_t      vl;
    logic [4:0] vd;
    logic       use_scalar;  // Operand A is the replicated scalar
    elen_t      scalar;
  } vinsn_t;

  // Result queue entry, one register file write
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_t;

  // Elements packed into one 64-bit word
  function automatic logic [3:0] elems_per_word(vew_e vew);
    case (vew)
      EW8:     return 4'd8;
      EW16:    return 4'd4;
      EW32:    return 4'd2;
      default: return 4'd1;
    endcase
  endfunction

endpackage

//--- valu_settings.svh
`ifndef VALU_SETTINGS_SVH
`define VALU_SETTINGS_SVH

// Sizes of the lane vector ALU

// Instructions held in flight
`define VALU_INSN_DEPTH 4

// Results waiting for a register file grant
`define VALU_RESULT_DEPTH 2

// Instruction ids, one done bit each
`define VALU_NR_VINSN 8

// Width of the element count vl
`define VALU_VLEN_W 8

// Register file words per vector register
`define VALU_REG_WORDS 16

// Register file word address width
`define VALU_ADDR_W 9

`endif
